/* testbench/mem_subsys_golden.txt */
# port we adr wdat sel exp_rdat exp_err inst_adr inst_exp_rdat inst_exp_err (hex)
# inst lines use adr/exp_rdat/exp_err for the inst port, last three columns only on both lines
data 1 80000000 deadbeef f 00000000 0 0 0 0
data 0 80000000 00000000 f deadbeef 0 0 0 0
data 1 80000004 01234567 f 00000000 0 0 0 0
data 1 80400004 89abcdef f 00000000 0 0 0 0
data 0 80000004 00000000 f 01234567 0 0 0 0
data 0 80400004 00000000 f 89abcdef 0 0 0 0
data 1 80000010 11223344 f 00000000 0 0 0 0
data 1 80000010 aabbccdd 5 00000000 0 0 0 0
data 0 80000010 00000000 f 11bb33dd 0 0 0 0
data 1 80000010 99000000 8 00000000 0 0 0 0
data 1 80000010 0000ee00 2 00000000 0 0 0 0
data 0 80000010 00000000 f 99bbeedd 0 0 0 0
data 1 80400020 cafef00d f 00000000 0 0 0 0
data 1 80400020 00001234 3 00000000 0 0 0 0
data 0 80400020 00000000 f cafe1234 0 0 0 0
inst 0 80000000 00000000 f deadbeef 0 0 0 0
inst 0 80400004 00000000 f 89abcdef 0 0 0 0
inst 0 80400020 00000000 f cafe1234 0 0 0 0
data 0 10000000 00000000 f 00000000 1 0 0 0
data 1 10000000 ffffffff f 00000000 1 0 0 0
inst 0 10000000 00000000 f 00000000 1 0 0 0
data 0 80800000 00000000 f 00000000 1 0 0 0
data 0 80000000 00000000 f deadbeef 0 0 0 0
data 0 80000400 00000000 f deadbeef 0 0 0 0
both 1 80000020 5555aaaa f 00000000 0 80000004 01234567 0
both 0 80000020 00000000 f 5555aaaa 0 80400004 89abcdef 0
both 0 80400020 00000000 f cafe1234 0 10000000 00000000 1
both 1 80400040 0badc0de f 00000000 0 80000010 99bbeedd 0
inst 0 80400040 00000000 f 0badc0de 0 0 0 0
both 0 00000000 00000000 f 00000000 1 80400040 0badc0de 0

/* compile.f */
design/mem_bus_pkg.sv
design/wb_bus_if.sv
design/bus_arbiter.sv
design/addr_decoder.sv
design/ram_bank.sv
design/mem_subsys_top.sv
testbench/mem_subsys_assert.sv
testbench/tb_mem_subsys.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the memory subsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module tb_mem_subsys \
    && ./obj_dir/Vtb_mem_subsys | tee /dev/stderr | grep -q "TEST RESULT: PASS" \
    && echo "Simulation finished without errors" \
    || { echo "Simulation reported errors"; exit 1; }

/* testbench/tb_mem_subsys.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mem_subsys import mem_bus_pkg::*; ();

    localparam int    TIMEOUT = 20;   // Cycles allowed per wait
    localparam string VEC_FILE = "testbench/mem_subsys_golden.txt";

    logic              sys_clk = 1'b0;
    logic              sys_rst;
    logic [ADDR_W-1:0] inst_adr;
    logic              inst_stb;
    logic [DATA_W-1:0] inst_rdat;
    logic              inst_ack;
    logic              inst_err;
    logic [ADDR_W-1:0] data_adr;
    logic [DATA_W-1:0] data_wdat;
    logic              data_we;
    logic [SEL_W-1:0]  data_sel;
    logic              data_stb;
    logic [DATA_W-1:0] data_rdat;
    logic              data_ack;
    logic              data_err;

    int          errors = 0;
    int          checks = 0;
    int          fd;
    int          n;
    string       line;
    logic [31:0] port;       // Four-character port name
    logic [31:0] f_we;
    logic [31:0] f_adr;
    logic [31:0] f_wdat;
    logic [31:0] f_sel;
    logic [31:0] f_rdat;
    logic [31:0] f_err;
    logic [31:0] f_iadr;     // Inst side of a paired line
    logic [31:0] f_irdat;
    logic [31:0] f_ierr;

    mem_subsys_top #(.RAM_WORDS(DEFAULT_RAM_WORDS)) uut (
        .sys_clk_i   (sys_clk),
        .sys_rst_i   (sys_rst),
        .inst_adr_i  (inst_adr),
        .inst_stb_i  (inst_stb),
        .inst_rdat_o (inst_rdat),
        .inst_ack_o  (inst_ack),
        .inst_err_o  (inst_err),
        .data_adr_i  (data_adr),
        .data_wdat_i (data_wdat),
        .data_we_i   (data_we),
        .data_sel_i  (data_sel),
        .data_stb_i  (data_stb),
        .data_rdat_o (data_rdat),
        .data_ack_o  (data_ack),
        .data_err_o  (data_err)
    );

    always #10 sys_clk = ~sys_clk;

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("error: t=%0t signal=%s expected=%h actual=%h",
                     $time, name, expected, actual);
        end
    endtask

    // Err must match and read data only matters on a good read
    task automatic check_response(input string pname, input logic ack, input logic err,
                                  input logic [31:0] rdat, input logic is_read,
                                  input logic [31:0] exp_rdat, input logic exp_err);
        check_value({pname, "_err_o"}, 32'(exp_err), 32'(err));
        if (ack && is_read && !exp_err)
            check_value({pname, "_rdat_o"}, exp_rdat, rdat);
    endtask

    // Raise stb on the chosen ports, hold it through the ack edge, then drop it
    task automatic run_transfer(input logic use_inst, input logic use_data);
        logic i_pend;
        logic d_pend;
        logic i_drop;
        logic d_drop;
        int   cyc;
        i_pend = use_inst;
        d_pend = use_data;
        i_drop = 1'b0;
        d_drop = 1'b0;
        cyc    = 0;
        if (use_inst) begin
            inst_adr = use_data ? f_iadr : f_adr;
            inst_stb = 1'b1;
        end
        if (use_data) begin
            data_adr  = f_adr;
            data_wdat = f_wdat;
            data_we   = f_we[0];
            data_sel  = f_sel[SEL_W-1:0];
            data_stb  = 1'b1;
        end
        while ((i_pend || d_pend) && cyc < TIMEOUT) begin
            @(negedge sys_clk);
            cyc++;
            if (i_drop) begin
                inst_stb = 1'b0;
                i_drop   = 1'b0;
            end
            if (d_drop) begin
                data_stb = 1'b0;
                d_drop   = 1'b0;
            end
            if (i_pend && (inst_ack || inst_err)) begin
                if (use_data)
                    check_response("inst", inst_ack, inst_err, inst_rdat, 1'b1,
                                   f_irdat, f_ierr[0]);
                else
                    check_response("inst", inst_ack, inst_err, inst_rdat, 1'b1,
                                   f_rdat, f_err[0]);
                i_pend = 1'b0;
                i_drop = 1'b1;
            end
            if (d_pend && (data_ack || data_err)) begin
                check_response("data", data_ack, data_err, data_rdat, !f_we[0],
                               f_rdat, f_err[0]);
                d_pend = 1'b0;
                d_drop = 1'b1;
            end
        end
        if (i_pend) begin
            errors++;
            $display("Timeout at %0t: inst port got no ack or err in %0d cycles", $time, TIMEOUT);
        end
        if (d_pend) begin
            errors++;
            $display("Timeout at %0t: data port got no ack or err in %0d cycles", $time, TIMEOUT);
        end
        @(negedge sys_clk);
        inst_stb = 1'b0;
        data_stb = 1'b0;
        @(negedge sys_clk);    // Idle cycle between lines
    endtask

    initial begin
        sys_rst   = 1'b1;
        inst_adr  = '0;
        inst_stb  = 1'b0;
        data_adr  = '0;
        data_wdat = '0;
        data_we   = 1'b0;
        data_sel  = '0;
        data_stb  = 1'b0;
        repeat (5) @(negedge sys_clk);
        sys_rst = 1'b0;

        fd = $fopen(VEC_FILE, "r");
        if (fd == 0) begin
            errors++;
            $display("Could not open the vector file %s", VEC_FILE);
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 0 && line.substr(0, 0) != "#") begin
                    n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h", port, f_we, f_adr,
                                f_wdat, f_sel, f_rdat, f_err, f_iadr, f_irdat, f_ierr);
                    if (n == 10) begin
                        if (port == "inst")
                            run_transfer(1'b1, 1'b0);
                        else if (port == "data")
                            run_transfer(1'b0, 1'b1);
                        else if (port == "both")
                            run_transfer(1'b1, 1'b1);
                        else begin
                            errors++;
                            $display("Unknown port name in vector line: %s", line);
                        end
                    end else if (n > 0) begin
                        errors++;
                        $display("Malformed vector line: %s", line);
                    end
                end
            end
            $fclose(fd);
        end
        if (checks == 0) begin
            errors++;
            $display("No vectors were run");
        end

        $display("Done: %0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* testbench/mem_subsys_assert.sv */
`timescale 1ns/1ps
`default_nettype none

// Port handshake rules seen at the arbiter
module mem_subsys_assert (
    input wire logic sys_clk_i,
    input wire logic sys_rst_i,
    input wire logic inst_stb_i,
    input wire logic inst_ack_o,
    input wire logic inst_err_o,
    input wire logic data_stb_i,
    input wire logic data_ack_o,
    input wire logic data_err_o
);

    a_inst_ack_err: assert property (@(posedge sys_clk_i) disable iff (sys_rst_i)
        !(inst_ack_o && inst_err_o))
        else $error("inst ack and err high together");

    a_data_ack_err: assert property (@(posedge sys_clk_i) disable iff (sys_rst_i)
        !(data_ack_o && data_err_o))
        else $error("data ack and err high together");

    // Only one port owns the bus
    a_one_ack: assert property (@(posedge sys_clk_i) disable iff (sys_rst_i)
        !(inst_ack_o && data_ack_o))
        else $error("inst and data ack high together");

    a_inst_ack_stb: assert property (@(posedge sys_clk_i) disable iff (sys_rst_i)
        inst_ack_o |-> inst_stb_i)
        else $error("inst ack without inst stb");

    a_data_ack_stb: assert property (@(posedge sys_clk_i) disable iff (sys_rst_i)
        data_ack_o |-> data_stb_i)
        else $error("data ack without data stb");

endmodule

bind bus_arbiter mem_subsys_assert u_arb_assert (
    .sys_clk_i  (sys_clk_i),
    .sys_rst_i  (sys_rst_i),
    .inst_stb_i (inst_stb_i),
    .inst_ack_o (inst_ack_o),
    .inst_err_o (inst_err_o),
    .data_stb_i (data_stb_i),
    .data_ack_o (data_ack_o),
    .data_err_o (data_err_o)
);

`default_nettype wire

/* design/mem_subsys_top.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_top import mem_bus_pkg::*; #(
    parameter int RAM_WORDS = DEFAULT_RAM_WORDS
) (
    input  wire logic              sys_clk_i,
    input  wire logic              sys_rst_i,

    // Instruction fetch port
    input  wire logic [ADDR_W-1:0] inst_adr_i,
    input  wire logic              inst_stb_i,
    output logic      [DATA_W-1:0] inst_rdat_o,
    output logic                   inst_ack_o,
    output logic                   inst_err_o,

    // Load/store port
    input  wire logic [ADDR_W-1:0] data_adr_i,
    input  wire logic [DATA_W-1:0] data_wdat_i,
    input  wire logic              data_we_i,
    input  wire logic [SEL_W-1:0]  data_sel_i,
    input  wire logic              data_stb_i,
    output logic      [DATA_W-1:0] data_rdat_o,
    output logic                   data_ack_o,
    output logic                   data_err_o
);

    wb_bus_if #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) arb_bus  ();   // Arbiter to decoder
    wb_bus_if #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) base_bus ();
    wb_bus_if #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) ext_bus  ();

    bus_arbiter #(
        .ADDR_W (ADDR_W),
        .DATA_W (DATA_W)
    ) u_arbiter (
        .sys_clk_i   (sys_clk_i),
        .sys_rst_i   (sys_rst_i),
        .inst_adr_i  (inst_adr_i),
        .inst_stb_i  (inst_stb_i),
        .inst_rdat_o (inst_rdat_o),
        .inst_ack_o  (inst_ack_o),
        .inst_err_o  (inst_err_o),
        .data_adr_i  (data_adr_i),
        .data_wdat_i (data_wdat_i),
        .data_we_i   (data_we_i),
        .data_sel_i  (data_sel_i),
        .data_stb_i  (data_stb_i),
        .data_rdat_o (data_rdat_o),
        .data_ack_o  (data_ack_o),
        .data_err_o  (data_err_o),
        .bus_m       (arb_bus)
    );

    addr_decoder u_decoder (
        .sys_clk_i (sys_clk_i),
        .sys_rst_i (sys_rst_i),
        .bus_s     (arb_bus),
        .base_m    (base_bus),
        .ext_m     (ext_bus)
    );

    // Base bank at 0x8000_0000
    ram_bank #(
        .RAM_WORDS (RAM_WORDS),
        .DATA_W    (DATA_W)
    ) base_ram (
        .sys_clk_i (sys_clk_i),
        .sys_rst_i (sys_rst_i),
        .bus_s     (base_bus)
    );

    // Ext bank at 0x8040_0000
    ram_bank #(
        .RAM_WORDS (RAM_WORDS),
        .DATA_W    (DATA_W)
    ) ext_ram (
        .sys_clk_i (sys_clk_i),
        .sys_rst_i (sys_rst_i),
        .bus_s     (ext_bus)
    );

endmodule

`default_nettype wire

/* design/ram_bank.sv */
`timescale 1ns/1ps
`default_nettype none

module ram_bank #(
    parameter int RAM_WORDS = mem_bus_pkg::DEFAULT_RAM_WORDS,
    parameter int DATA_W    = mem_bus_pkg::DATA_W
) (
    input  wire logic sys_clk_i,
    input  wire logic sys_rst_i,

    wb_bus_if.slave   bus_s
);

    localparam int IDX_W = $clog2(RAM_WORDS);
    localparam int SEL_W = DATA_W / 8;

    logic [DATA_W-1:0] mem [RAM_WORDS];
    logic [DATA_W-1:0] rdat_q;
    logic              ack_q;
    logic [IDX_W-1:0]  idx;
    logic              access;

    assign idx    = bus_s.adr[IDX_W+1:2];     // Word index with upper bits aliased
    assign access = bus_s.stb && !ack_q;      // No second ack back to back

    always_ff @(posedge sys_clk_i or posedge sys_rst_i) begin
        if (sys_rst_i)
            ack_q <= 1'b0;
        else
            ack_q <= access;
    end

    // Array and read data
    always_ff @(posedge sys_clk_i) begin
        if (access) begin
            if (bus_s.we) begin
                for (int b = 0; b < SEL_W; b++) begin
                    if (bus_s.sel[b])
                        mem[idx][8*b +: 8] <= bus_s.wdat[8*b +: 8];
                end
            end else begin
                rdat_q <= mem[idx];
            end
        end
    end

    assign bus_s.rdat = rdat_q;
    assign bus_s.ack  = ack_q;
    assign bus_s.err  = 1'b0;     // Every word in range answers

endmodule

`default_nettype wire

/* design/addr_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module addr_decoder import mem_bus_pkg::*; (
    input  wire logic sys_clk_i,
    input  wire logic sys_rst_i,

    wb_bus_if.slave   bus_s,     // From the arbiter
    wb_bus_if.master  base_m,    // To the base bank
    wb_bus_if.master  ext_m      // To the ext bank
);

    bank_sel_t route;     // Bank that owns the open transfer
    logic      err_q;
    logic      hit_base;
    logic      hit_ext;
    logic      idle;

    assign hit_base = (bus_s.adr & RAM_ADDR_MSK) == BASE_RAM_ADDR;
    assign hit_ext  = (bus_s.adr & RAM_ADDR_MSK) == EXT_RAM_ADDR;
    assign idle     = (route == BANK_NONE) && !err_q;

    always_ff @(posedge sys_clk_i or posedge sys_rst_i) begin
        if (sys_rst_i) begin
            route <= BANK_NONE;
            err_q <= 1'b0;
        end else if (err_q) begin
            err_q <= 1'b0;                  // Error lasts one cycle
        end else if (bus_s.ack) begin
            route <= BANK_NONE;             // Bank answered so close transfer
        end else if (bus_s.stb && idle) begin
            if (hit_base)
                route <= BANK_BASE;
            else if (hit_ext)
                route <= BANK_EXT;
            else
                err_q <= 1'b1;              // Unmapped
        end
    end

    // Request fields fan out and only stb is routed
    assign base_m.adr  = bus_s.adr;
    assign base_m.wdat = bus_s.wdat;
    assign base_m.we   = bus_s.we;
    assign base_m.sel  = bus_s.sel;
    assign base_m.stb  = bus_s.stb && (route == BANK_BASE);

    assign ext_m.adr   = bus_s.adr;
    assign ext_m.wdat  = bus_s.wdat;
    assign ext_m.we    = bus_s.we;
    assign ext_m.sel   = bus_s.sel;
    assign ext_m.stb   = bus_s.stb && (route == BANK_EXT);

    // Response from the routed bank
    assign bus_s.rdat = (route == BANK_EXT) ? ext_m.rdat : base_m.rdat;
    assign bus_s.ack  = ((route == BANK_BASE) && base_m.ack) ||
                        ((route == BANK_EXT) && ext_m.ack);
    assign bus_s.err  = err_q ||
                        ((route == BANK_BASE) && base_m.err) ||
                        ((route == BANK_EXT) && ext_m.err);

endmodule

`default_nettype wire

/* design/bus_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter #(
    parameter int ADDR_W = mem_bus_pkg::ADDR_W,
    parameter int DATA_W = mem_bus_pkg::DATA_W
) (
    input  wire logic                sys_clk_i,
    input  wire logic                sys_rst_i,

    // Instruction port, read only
    input  wire logic [ADDR_W-1:0]   inst_adr_i,
    input  wire logic                inst_stb_i,
    output logic      [DATA_W-1:0]   inst_rdat_o,
    output logic                     inst_ack_o,
    output logic                     inst_err_o,

    // Data port
    input  wire logic [ADDR_W-1:0]   data_adr_i,
    input  wire logic [DATA_W-1:0]   data_wdat_i,
    input  wire logic                data_we_i,
    input  wire logic [DATA_W/8-1:0] data_sel_i,
    input  wire logic                data_stb_i,
    output logic      [DATA_W-1:0]   data_rdat_o,
    output logic                     data_ack_o,
    output logic                     data_err_o,

    wb_bus_if.master                 bus_m
);

    logic busy;          // Transfer open on the shared bus
    logic grant_data;    // 1 when the data port owns the bus
    logic last_data;     // 1 when the data port was served last
    logic pick_data;
    logic done;

    // Tie goes round robin and a lone request wins
    assign pick_data = data_stb_i && (!inst_stb_i || !last_data);
    assign done      = bus_m.ack || bus_m.err;

    always_ff @(posedge sys_clk_i or posedge sys_rst_i) begin
        if (sys_rst_i) begin
            busy       <= 1'b0;
            grant_data <= 1'b0;
            last_data  <= 1'b0;      // Inst counts as served so data wins first tie
        end else if (!busy) begin
            if (inst_stb_i || data_stb_i) begin
                busy       <= 1'b1;
                grant_data <= pick_data;
            end
        end else if (done) begin
            busy      <= 1'b0;
            last_data <= grant_data;
        end
    end

    // Granted port drives the shared bus
    assign bus_m.stb  = busy;
    assign bus_m.adr  = grant_data ? data_adr_i : inst_adr_i;
    assign bus_m.wdat = grant_data ? data_wdat_i : '0;
    assign bus_m.we   = grant_data && data_we_i;   // Inst fetch never writes
    assign bus_m.sel  = grant_data ? data_sel_i : '1;

    // Responses go back to the owner only
    assign inst_ack_o  = busy && !grant_data && bus_m.ack;
    assign inst_err_o  = busy && !grant_data && bus_m.err;
    assign inst_rdat_o = (busy && !grant_data) ? bus_m.rdat : '0;
    assign data_ack_o  = busy && grant_data && bus_m.ack;
    assign data_err_o  = busy && grant_data && bus_m.err;
    assign data_rdat_o = (busy && grant_data) ? bus_m.rdat : '0;

endmodule

`default_nettype wire

/* design/wb_bus_if.sv */
`timescale 1ns/1ps
`default_nettype none

// Single-master stb/ack bus with one transfer in flight at a time
interface wb_bus_if #(
    parameter int ADDR_W = mem_bus_pkg::ADDR_W,
    parameter int DATA_W = mem_bus_pkg::DATA_W
);

    logic [ADDR_W-1:0]   adr;
    logic [DATA_W-1:0]   wdat;
    logic                we;
    logic [DATA_W/8-1:0] sel;      // Byte lane enables
    logic                stb;      // Held until ack or err
    logic [DATA_W-1:0]   rdat;
    logic                ack;      // One cycle per transfer
    logic                err;      // One cycle in place of ack

    modport master (
        output adr, wdat, we, sel, stb,
        input  rdat, ack, err
    );

    modport slave (
        input  adr, wdat, we, sel, stb,
        output rdat, ack, err
    );

endinterface

`default_nettype wire

/* design/mem_bus_pkg.sv */
`default_nettype none

package mem_bus_pkg;

    // Bus widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int SEL_W  = DATA_W / 8;        // One select bit per byte lane

    // Address map with one 4 MB mask for both banks
    localparam logic [ADDR_W-1:0] BASE_RAM_ADDR = 32'h8000_0000;
    localparam logic [ADDR_W-1:0] EXT_RAM_ADDR  = 32'h8040_0000;
    localparam logic [ADDR_W-1:0] RAM_ADDR_MSK  = 32'hFFC0_0000;

    // On-chip bank depth in words
    localparam int DEFAULT_RAM_WORDS = 256;

    // Routing state of the decoder
    typedef enum logic [1:0] {
        BANK_NONE = 2'd0,   // No transfer open
        BANK_BASE = 2'd1,
        BANK_EXT  = 2'd2
    } bank_sel_t;

endpackage

`default_nettype wire
